/* design/xoodyak_config.svh */
`ifndef XOODYAK_CONFIG_SVH
`define XOODYAK_CONFIG_SVH

// Datapath widths
`define XOODYAK_STATE_W 384
`define XOODYAK_PLANE_W 128
`define XOODYAK_LANE_W 32

// Permutation schedule, 3 rounds per clock over 4 clocks
`define XOODOO_ROUNDS 12
`define XOODOO_ROUNDS_PER_CYCLE 3
`define XOODOO_PERM_CYCLES 4

// Command FIFO depth, equal to the host's starting command credits
`define CMD_FIFO_DEPTH 2

// Output words the DUT may send before the sink returns credits
`define OUT_CREDITS_INIT 2

`endif

/* design/xoodyak_pkg.sv */
`default_nettype none

`include "xoodyak_config.svh"

package xoodyak_pkg;

        // One plane, lane x sits at bits 32x upward
        typedef logic [`XOODYAK_PLANE_W/`XOODYAK_LANE_W-1:0][`XOODYAK_LANE_W-1:0] plane_t;

        // Full state, plane y sits at bits 128y upward
        typedef plane_t [`XOODYAK_STATE_W/`XOODYAK_PLANE_W-1:0] xoodyak_state_t;

        // Host command codes, code 3 is unused
        typedef enum logic [1:0] {
                CMD_INIT    = 2'd0,
                CMD_ABSORB  = 2'd1,
                CMD_SQUEEZE = 2'd2
        } cmd_op_t;

        // One FIFO entry
        typedef struct packed {
                cmd_op_t op;
                plane_t  block;
        } cmd_t;

        // Round constants in round order, LSB lands on z = 0 of lane 0
        localparam logic [`XOODYAK_LANE_W-1:0] XOODOO_RC [`XOODOO_ROUNDS] = '{
                32'h058, 32'h038, 32'h3c0, 32'h0d0, 32'h120, 32'h014,
                32'h060, 32'h02c, 32'h380, 32'h0f0, 32'h1a0, 32'h012
        };

endpackage

`default_nettype wire

/* design/perm_ctrl_if.sv */
`default_nettype none

`include "xoodyak_config.svh"

interface perm_ctrl_if;

        // Pulse from the sequencer, one cycle, starts a permutation
        logic start;
        // High for the 4 clocks of a permutation
        logic active;
        // Which group of three rounds runs this clock
        logic [$clog2(`XOODOO_PERM_CYCLES)-1:0] round_group;
        // Final group of the permutation
        logic last_group;

        modport fsm (output start, input active, input last_group);

        modport counter (input start, output active, output round_group, output last_group);

        modport datapath (input active, input round_group);

endinterface

`default_nettype wire

/* design/cmd_fifo.sv */
`default_nettype none

`include "xoodyak_config.svh"

module cmd_fifo import xoodyak_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic wr_en,
        input  cmd_t wr_cmd,
        input  logic rd_en,
        output cmd_t rd_cmd,
        output logic not_empty,
        output logic credit
);

        localparam int DEPTH = `CMD_FIFO_DEPTH;
        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        // Entry storage
        cmd_t mem [DEPTH];

        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             full;
        logic             do_rd;

        assign full      = (count == CNT_W'(DEPTH));
        assign not_empty = (count != '0);
        assign do_rd     = rd_en && not_empty;

        // Head entry read combinationally
        assign rd_cmd = mem[rd_ptr];

        // One host credit goes back with every pop
        assign credit = do_rd;

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        mem[wr_ptr] <= wr_cmd;
                end
        end

        // --------------------------------------------------
        // Pointers and fill count
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_en) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (do_rd) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        // Simultaneous push and pop leaves the count alone
                        case ({wr_en, do_rd})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // Host spent a credit it did not hold
        a_no_overflow: assert property (@(posedge clk) disable iff (reset)
                wr_en |-> (!full || do_rd));

endmodule

`default_nettype wire

/* design/cyclist_fsm.sv */
`default_nettype none

`include "xoodyak_config.svh"

module cyclist_fsm import xoodyak_pkg::*; (
        input  logic        clk,
        input  logic        reset,
        input  cmd_op_t     head_op,
        input  logic        head_valid,
        output logic        pop,
        output logic        load_zero,
        output logic        load_absorb,
        output logic        out_valid,
        input  logic        out_credit,
        perm_ctrl_if.fsm    ctrl
);

        localparam int CRED_W = $clog2(`OUT_CREDITS_INIT + 1);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_PERM_ABSORB,
                ST_PERM_SQUEEZE
        } fsm_state_t;

        fsm_state_t        state;
        fsm_state_t        state_next;
        logic [CRED_W-1:0] credits;
        logic              is_squeeze;
        logic              spend;
        logic              perm_done;

        assign is_squeeze = (head_op == CMD_SQUEEZE);
        assign perm_done  = ctrl.active && ctrl.last_group;

        // Pop only from idle and hold a squeeze back while no output credit is left
        assign pop = (state == ST_IDLE) && head_valid && !(is_squeeze && credits == '0);

        assign load_zero   = pop && (head_op == CMD_INIT);
        assign load_absorb = pop && (head_op == CMD_ABSORB);
        assign ctrl.start  = pop && (head_op == CMD_ABSORB || is_squeeze);

        // Squeeze reserves its output credit at the pop
        assign spend = pop && is_squeeze;

        always_comb begin
                state_next = state;
                case (state)
                        ST_IDLE: begin
                                if (pop && head_op == CMD_ABSORB) begin
                                        state_next = ST_PERM_ABSORB;
                                end else if (spend) begin
                                        state_next = ST_PERM_SQUEEZE;
                                end
                        end
                        ST_PERM_ABSORB, ST_PERM_SQUEEZE: begin
                                if (perm_done) begin
                                        state_next = ST_IDLE;
                                end
                        end
                        default: state_next = ST_IDLE;
                endcase
        end

        // --------------------------------------------------
        // State, output strobe and credit count
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (reset) begin
                        state     <= ST_IDLE;
                        out_valid <= 1'b0;
                        credits   <= CRED_W'(`OUT_CREDITS_INIT);
                end else begin
                        state <= state_next;
                        // Plane 0 is final on the clock after the last group
                        out_valid <= (state == ST_PERM_SQUEEZE) && perm_done;
                        credits   <= credits + CRED_W'(out_credit) - CRED_W'(spend);
                end
        end

        // Sink returned more credits than it was given
        a_credit_bound: assert property (@(posedge clk) disable iff (reset)
                credits <= CRED_W'(`OUT_CREDITS_INIT));

        // Only the three defined codes reach the FIFO head
        a_op_legal: assert property (@(posedge clk) disable iff (reset)
                head_valid |-> head_op inside {CMD_INIT, CMD_ABSORB, CMD_SQUEEZE});

endmodule

`default_nettype wire

/* design/round_counter.sv */
`default_nettype none

`include "xoodyak_config.svh"

module round_counter (
        input  logic        clk,
        input  logic        reset,
        perm_ctrl_if.counter ctrl
);

        localparam int GRP_W = $clog2(`XOODOO_PERM_CYCLES);

        // Last group flagged in the same clock it runs
        assign ctrl.last_group = ctrl.active &&
                (ctrl.round_group == GRP_W'(`XOODOO_PERM_CYCLES - 1));

        always_ff @(posedge clk) begin
                if (reset) begin
                        ctrl.active      <= 1'b0;
                        ctrl.round_group <= '0;
                end else if (ctrl.start) begin
                        ctrl.active      <= 1'b1;
                        ctrl.round_group <= '0;
                end else if (ctrl.last_group) begin
                        // Drop out after group 3
                        ctrl.active      <= 1'b0;
                        ctrl.round_group <= '0;
                end else if (ctrl.active) begin
                        ctrl.round_group <= ctrl.round_group + 1'b1;
                end
        end

        // Sequencer only starts from idle
        a_no_restart: assert property (@(posedge clk) disable iff (reset)
                ctrl.start |-> !ctrl.active);

endmodule

`default_nettype wire

/* design/xoodoo_rounds.sv */
`default_nettype none

`include "xoodyak_config.svh"

module xoodoo_rounds import xoodyak_pkg::*; (
        input  xoodyak_state_t   state_in,
        perm_ctrl_if.datapath    ctrl,
        output xoodyak_state_t   state_out
);

        localparam int LANES = `XOODYAK_PLANE_W / `XOODYAK_LANE_W;
        localparam int RPC   = `XOODOO_ROUNDS_PER_CYCLE;

        // Cyclic shift toward higher z
        function automatic logic [`XOODYAK_LANE_W-1:0] rotl(
                input logic [`XOODYAK_LANE_W-1:0] v,
                input int                         n
        );
                rotl = (v << n) | (v >> (`XOODYAK_LANE_W - n));
        endfunction

        // --------------------------------------------------
        // One Xoodoo round
        // --------------------------------------------------
        function automatic xoodyak_state_t xoodoo_round(
                input xoodyak_state_t             a,
                input logic [`XOODYAK_LANE_W-1:0] rc
        );
                xoodyak_state_t t;
                xoodyak_state_t w;
                xoodyak_state_t c;
                plane_t         p;
                plane_t         e;
                int             x;
                // Theta, column parity folded back into every plane
                p = a[0] ^ a[1] ^ a[2];
                for (x = 0; x < LANES; x++) begin
                        e[x] = rotl(p[(x + LANES - 1) % LANES], 5)
                             ^ rotl(p[(x + LANES - 1) % LANES], 14);
                end
                t[0] = a[0] ^ e;
                t[1] = a[1] ^ e;
                t[2] = a[2] ^ e;
                // Rho west, plane 1 moves one lane, plane 2 rotates by 11
                w[0] = t[0];
                for (x = 0; x < LANES; x++) begin
                        w[1][x] = t[1][(x + LANES - 1) % LANES];
                        w[2][x] = rotl(t[2][x], 11);
                end
                // Iota on lane 0 of plane 0
                w[0][0] = w[0][0] ^ rc;
                // Chi
                c[0] = w[0] ^ (~w[1] & w[2]);
                c[1] = w[1] ^ (~w[2] & w[0]);
                c[2] = w[2] ^ (~w[0] & w[1]);
                // Rho east, plane 1 by one bit, plane 2 two lanes and 8 bits
                xoodoo_round[0] = c[0];
                for (x = 0; x < LANES; x++) begin
                        xoodoo_round[1][x] = rotl(c[1][x], 1);
                        xoodoo_round[2][x] = rotl(c[2][(x + LANES - 2) % LANES], 8);
                end
        endfunction

        xoodyak_state_t stage [RPC + 1];

        assign stage[0] = state_in;

        // Three chained rounds, constants picked by group and position
        for (genvar i = 0; i < RPC; i++) begin : g_round
                logic [`XOODYAK_LANE_W-1:0] rc;
                assign rc           = XOODOO_RC[int'(ctrl.round_group) * RPC + i];
                assign stage[i + 1] = xoodoo_round(stage[i], rc);
        end

        assign state_out = stage[RPC];

endmodule

`default_nettype wire

/* design/xoodyak_state.sv */
`default_nettype none

`include "xoodyak_config.svh"

module xoodyak_state import xoodyak_pkg::*; (
        input  logic            clk,
        input  logic            reset,
        input  logic            load_zero,
        input  logic            load_absorb,
        input  plane_t          block,
        output xoodyak_state_t  perm_in,
        input  xoodyak_state_t  perm_out,
        perm_ctrl_if.datapath   ctrl,
        output plane_t          plane0
);

        xoodyak_state_t state;
        xoodyak_state_t state_next;

        // --------------------------------------------------
        // Update paths with init over absorb over permute
        // --------------------------------------------------
        always_comb begin
                state_next = state;
                if (load_zero) begin
                        state_next = '0;
                end else if (load_absorb) begin
                        // Block goes into plane 0 and pad byte 01 into plane 1
                        state_next[0]       = state[0] ^ block;
                        state_next[1][0][7:0] = state[1][0][7:0] ^ 8'h01;
                end else if (ctrl.active) begin
                        state_next = perm_out;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= '0;
                end else begin
                        state <= state_next;
                end
        end

        // Each group works from the previous group's registered result
        assign perm_in = state;

        // Squeeze data is plane 0 of the register
        assign plane0 = state[0];

        // Loads from the sequencer never overlap a running permutation
        a_no_load_in_perm: assert property (@(posedge clk) disable iff (reset)
                (load_zero || load_absorb) |-> !ctrl.active);

endmodule

`default_nettype wire

/* design/xoodyak_hash.sv */
`default_nettype none

`include "xoodyak_config.svh"

module xoodyak_hash import xoodyak_pkg::*; (
        input  logic    clk,
        input  logic    reset,

        // Credit based command side
        input  logic    cmd_valid,
        input  cmd_op_t cmd_op,
        input  plane_t  cmd_block,
        output logic    cmd_credit,

        // Credit based output side
        output logic    out_valid,
        output plane_t  out_data,
        input  logic    out_credit
);

        cmd_t           fifo_in;
        cmd_t           fifo_head;
        logic           head_valid;
        logic           pop;
        logic           load_zero;
        logic           load_absorb;
        xoodyak_state_t perm_in;
        xoodyak_state_t perm_out;

        perm_ctrl_if perm_ctrl ();

        assign fifo_in.op    = cmd_op;
        assign fifo_in.block = cmd_block;

        // --------------------------------------------------
        // Command path
        // --------------------------------------------------
        cmd_fifo u_cmd_fifo (
                .clk       (clk),
                .reset     (reset),
                .wr_en     (cmd_valid),
                .wr_cmd    (fifo_in),
                .rd_en     (pop),
                .rd_cmd    (fifo_head),
                .not_empty (head_valid),
                .credit    (cmd_credit)
        );

        cyclist_fsm u_cyclist_fsm (
                .clk         (clk),
                .reset       (reset),
                .head_op     (fifo_head.op),
                .head_valid  (head_valid),
                .pop         (pop),
                .load_zero   (load_zero),
                .load_absorb (load_absorb),
                .out_valid   (out_valid),
                .out_credit  (out_credit),
                .ctrl        (perm_ctrl.fsm)
        );

        round_counter u_round_counter (
                .clk   (clk),
                .reset (reset),
                .ctrl  (perm_ctrl.counter)
        );

        // --------------------------------------------------
        // State and permutation
        // --------------------------------------------------
        xoodoo_rounds u_xoodoo_rounds (
                .state_in  (perm_in),
                .ctrl      (perm_ctrl.datapath),
                .state_out (perm_out)
        );

        xoodyak_state u_xoodyak_state (
                .clk         (clk),
                .reset       (reset),
                .load_zero   (load_zero),
                .load_absorb (load_absorb),
                .block       (fifo_head.block),
                .perm_in     (perm_in),
                .perm_out    (perm_out),
                .ctrl        (perm_ctrl.datapath),
                .plane0      (out_data)
        );

endmodule

`default_nettype wire

/* sim/xoodoo_model_pkg.sv */
`default_nettype none

`include "xoodyak_config.svh"

package xoodoo_model_pkg;

        import xoodyak_pkg::*;

        typedef logic [`XOODYAK_LANE_W-1:0] lane_t;

        // Reference copy of the cyclist state
        xoodyak_state_t model_state;

        // Lane rotation toward higher z
        function automatic lane_t rol(input lane_t v, input int n);
                return (v << n) | (v >> (`XOODYAK_LANE_W - n));
        endfunction

        // --------------------------------------------------
        // Xoodoo[12], lanes held as a[y][x]
        // --------------------------------------------------
        function automatic xoodyak_state_t permute(input xoodyak_state_t s_in);
                lane_t          a [3][4];
                lane_t          b [3][4];
                lane_t          p [4];
                lane_t          e [4];
                xoodyak_state_t s_out;
                for (int y = 0; y < 3; y++) begin
                        for (int x = 0; x < 4; x++) begin
                                a[y][x] = s_in[y][x];
                        end
                end
                for (int r = 0; r < `XOODOO_ROUNDS; r++) begin
                        // Theta with the (1,5) and (1,14) parity shifts
                        for (int x = 0; x < 4; x++) begin
                                p[x] = a[0][x] ^ a[1][x] ^ a[2][x];
                        end
                        for (int x = 0; x < 4; x++) begin
                                e[x] = rol(p[(x + 3) % 4], 5) ^ rol(p[(x + 3) % 4], 14);
                        end
                        for (int y = 0; y < 3; y++) begin
                                for (int x = 0; x < 4; x++) begin
                                        a[y][x] = a[y][x] ^ e[x];
                                end
                        end
                        // Rho west (1,0) and (0,11), then iota
                        for (int x = 0; x < 4; x++) begin
                                b[0][x] = a[0][x];
                                b[1][x] = a[1][(x + 3) % 4];
                                b[2][x] = rol(a[2][x], 11);
                        end
                        b[0][0] = b[0][0] ^ XOODOO_RC[r];
                        // Chi across the three planes
                        for (int y = 0; y < 3; y++) begin
                                for (int x = 0; x < 4; x++) begin
                                        a[y][x] = b[y][x] ^ (~b[(y + 1) % 3][x] & b[(y + 2) % 3][x]);
                                end
                        end
                        // Rho east (0,1) and (2,8)
                        for (int x = 0; x < 4; x++) begin
                                b[0][x] = a[0][x];
                                b[1][x] = rol(a[1][x], 1);
                                b[2][x] = rol(a[2][(x + 2) % 4], 8);
                        end
                        a = b;
                end
                for (int y = 0; y < 3; y++) begin
                        for (int x = 0; x < 4; x++) begin
                                s_out[y][x] = a[y][x];
                        end
                end
                return s_out;
        endfunction

        // --------------------------------------------------
        // Command rules
        // --------------------------------------------------
        function automatic void model_init();
                model_state = '0;
        endfunction

        // Block into plane 0, pad byte into plane 1, then permute
        function automatic void model_absorb(input plane_t blk);
                model_state[0]          = model_state[0] ^ blk;
                model_state[1][0][7:0]  = model_state[1][0][7:0] ^ 8'h01;
                model_state             = permute(model_state);
        endfunction

        // Permute first, plane 0 is the output word
        function automatic plane_t model_squeeze();
                model_state = permute(model_state);
                return model_state[0];
        endfunction

endpackage

`default_nettype wire

/* sim/tb_xoodyak_hash.sv */
`default_nettype none

`include "xoodyak_config.svh"

module tb_xoodyak_hash import xoodyak_pkg::*, xoodoo_model_pkg::*;;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int NUM_DIRECTED    = 3;
        localparam int NUM_RANDOM      = 40;
        // Enough squeezes to fill both the output credits and the FIFO
        localparam int NUM_HOLD        = `OUT_CREDITS_INIT + `CMD_FIFO_DEPTH;
        localparam int NUM_CMDS        = NUM_DIRECTED + NUM_RANDOM + NUM_HOLD;
        localparam int HOLD_WINDOW     = 40;
        localparam int WATCHDOG_CYCLES = NUM_CMDS * 10 + HOLD_WINDOW + 100;

        // Sink behavior for returning output credits
        localparam int CREDIT_HOLD   = 0;
        localparam int CREDIT_FREE   = 1;
        localparam int CREDIT_RANDOM = 2;

        logic    clk;
        logic    reset;
        logic    cmd_valid;
        cmd_op_t cmd_op;
        plane_t  cmd_block;
        logic    cmd_credit;
        logic    out_valid;
        plane_t  out_data;
        logic    out_credit;

        // Host and sink bookkeeping
        int     host_credits;
        int     sink_credits;
        int     owed_credits;
        int     credit_pulses;
        int     cmds_sent;
        int     outputs_seen;
        int     mismatch_count;
        int     other_count;
        int     credit_mode;
        string  test_name;
        plane_t expected_q [$];
        string  name_q [$];

        xoodyak_hash dut0 (
                .clk        (clk),
                .reset      (reset),
                .cmd_valid  (cmd_valid),
                .cmd_op     (cmd_op),
                .cmd_block  (cmd_block),
                .cmd_credit (cmd_credit),
                .out_valid  (out_valid),
                .out_data   (out_data),
                .out_credit (out_credit)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // Run length bound from the command count
        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("watchdog expired, outputs or command credits never arrived");
                $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                         other_count + 1);
                $display("Done: errors found");
                $finish;
        end

        // --------------------------------------------------
        // Monitor sampled mid-cycle on the falling edge
        // --------------------------------------------------
        task automatic sample_outputs();
                plane_t exp_data;
                string  exp_name;
                // Both outputs quiet until the first command
                if (cmds_sent == 0) begin
                        assert (!out_valid && !cmd_credit) else begin
                                other_count++;
                                $display("out_valid or cmd_credit high before any command");
                        end
                end
                if (cmd_credit) begin
                        credit_pulses++;
                        host_credits++;
                        assert (host_credits <= `CMD_FIFO_DEPTH) else begin
                                other_count++;
                                $display("more command credits returned than commands sent");
                        end
                end
                if (out_valid) begin
                        outputs_seen++;
                        assert (sink_credits > 0) else begin
                                other_count++;
                                $display("output word sent without an output credit");
                        end
                        sink_credits--;
                        owed_credits++;
                        assert (expected_q.size() != 0) else begin
                                other_count++;
                                $display("output word arrived with no squeeze pending");
                        end
                        if (expected_q.size() != 0) begin
                                exp_data = expected_q.pop_front();
                                exp_name = name_q.pop_front();
                                assert (out_data === exp_data) else begin
                                        mismatch_count++;
                                        $display("mismatch %s: expected %h, actual %h",
                                                 exp_name, exp_data, out_data);
                                end
                        end
                end
        endtask

        // One-cycle credit pulses back to the DUT
        task automatic return_credit();
                out_credit = 1'b0;
                if (owed_credits > 0) begin
                        if (credit_mode == CREDIT_FREE ||
                            (credit_mode == CREDIT_RANDOM && $urandom % 2 == 1)) begin
                                out_credit = 1'b1;
                                owed_credits--;
                                sink_credits++;
                        end
                end
        endtask

        task automatic tick();
                @(negedge clk);
                sample_outputs();
                return_credit();
        endtask

        function automatic plane_t random_plane();
                return {$urandom, $urandom, $urandom, $urandom};
        endfunction

        // --------------------------------------------------
        // Host side spends one credit per command
        // --------------------------------------------------
        task automatic send_cmd(input cmd_op_t op, input plane_t blk);
                while (host_credits == 0) begin
                        tick();
                end
                cmd_valid = 1'b1;
                cmd_op    = op;
                cmd_block = blk;
                host_credits--;
                cmds_sent++;
                case (op)
                        CMD_INIT:   model_init();
                        CMD_ABSORB: model_absorb(blk);
                        default: begin
                                expected_q.push_back(model_squeeze());
                                name_q.push_back(test_name);
                        end
                endcase
                tick();
                cmd_valid = 1'b0;
        endtask

        // Wait for every output, command credit and sink credit to settle
        task automatic drain();
                while (expected_q.size() != 0 || host_credits != `CMD_FIFO_DEPTH ||
                       owed_credits != 0) begin
                        tick();
                end
        endtask

        initial begin
                int i;
                int sel;
                int held;
                void'($urandom(32'h3ed9));
                reset          = 1'b1;
                cmd_valid      = 1'b0;
                cmd_op         = CMD_INIT;
                cmd_block      = '0;
                out_credit     = 1'b0;
                host_credits   = `CMD_FIFO_DEPTH;
                sink_credits   = `OUT_CREDITS_INIT;
                owed_credits   = 0;
                credit_pulses  = 0;
                cmds_sent      = 0;
                outputs_seen   = 0;
                mismatch_count = 0;
                other_count    = 0;
                credit_mode    = CREDIT_FREE;
                model_init();
                repeat (10) @(negedge clk);
                reset = 1'b0;

                // Nothing should move while idle after reset
                test_name = "reset_quiet";
                repeat (5) tick();

                // Zero state squeezed directly and after an explicit init
                test_name = "squeeze_after_reset";
                send_cmd(CMD_SQUEEZE, '0);
                test_name = "squeeze_after_init";
                send_cmd(CMD_INIT, random_plane());
                send_cmd(CMD_SQUEEZE, '0);
                drain();

                // Random command mix while the sink returns credits at random
                test_name   = "random_sequence";
                credit_mode = CREDIT_RANDOM;
                for (i = 0; i < NUM_RANDOM; i++) begin
                        sel = $urandom % 8;
                        if (sel == 0) begin
                                send_cmd(CMD_INIT, random_plane());
                        end else if (sel < 5) begin
                                send_cmd(CMD_ABSORB, random_plane());
                        end else begin
                                send_cmd(CMD_SQUEEZE, random_plane());
                        end
                        repeat ($urandom % 3) tick();
                end
                credit_mode = CREDIT_FREE;
                drain();

                // --------------------------------------------------
                // Output back-pressure with credits withheld
                // --------------------------------------------------
                test_name   = "output_backpressure";
                credit_mode = CREDIT_HOLD;
                held        = outputs_seen;
                for (i = 0; i < NUM_HOLD; i++) begin
                        send_cmd(CMD_SQUEEZE, '0);
                end
                repeat (HOLD_WINDOW) tick();
                assert (outputs_seen - held <= `OUT_CREDITS_INIT) else begin
                        other_count++;
                        $display("more output words than output credits while credits were held");
                end
                assert (host_credits == 0) else begin
                        other_count++;
                        $display("command credits kept returning while the output was stalled");
                end
                credit_mode = CREDIT_FREE;
                drain();

                // One credit pulse per command and all credits back home
                assert (credit_pulses == cmds_sent) else begin
                        mismatch_count++;
                        $display("mismatch command_credits: expected %0d, actual %0d",
                                 cmds_sent, credit_pulses);
                end
                assert (host_credits == `CMD_FIFO_DEPTH) else begin
                        mismatch_count++;
                        $display("mismatch host_credits: expected %0d, actual %0d",
                                 `CMD_FIFO_DEPTH, host_credits);
                end

                $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                         other_count);
                if (mismatch_count + other_count == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* xoodyak_hash.f */
+incdir+design
design/xoodyak_pkg.sv
design/perm_ctrl_if.sv
design/cmd_fifo.sv
design/cyclist_fsm.sv
design/round_counter.sv
design/xoodoo_rounds.sv
design/xoodyak_state.sv
design/xoodyak_hash.sv
sim/xoodoo_model_pkg.sv
sim/tb_xoodyak_hash.sv

/* Makefile */
TOP := tb_xoodyak_hash

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f xoodyak_hash.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
